/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int xlen = 64;
    localparam int dmem_depth = 64;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [5:0] dmem_addr_t; // doubleword index.

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b // lui.
    } alu_op_t;

    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
        logic    wb_link; // write pc+4.
    } ctrl_t;

    localparam ctrl_t nop_ctrl = '{
        alu_op:    alu_add,
        use_imm:   1'b0,
        reg_write: 1'b0,
        mem_read:  1'b0,
        mem_write: 1'b0,
        is_branch: 1'b0,
        branch_ne: 1'b0,
        is_jal:    1'b0,
        wb_link:   1'b0
    };

endpackage

`default_nettype wire

/* rtl/wb_bus_if.sv */
`default_nettype none

// result of one stage as seen by forwarding and the register file.
interface wb_bus_if import core_pkg::*; ();

    logic      valid;
    reg_addr_t rd;
    word_t     data;
    logic      is_load;

    modport source (
        output valid, rd, data, is_load
    );

    modport sink (
        input valid, rd, data, is_load
    );

endinterface

`default_nettype wire

/* rtl/fetch_stage.sv */
`default_nettype none

module fetch_stage import core_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  bubble,
    input  wire logic  flush,
    input  wire word_t target,
    input  wire inst_t inst,
    output word_t      pc,
    output word_t      id_pc,
    output inst_t      id_inst,
    output logic       id_valid
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            id_valid <= 1'b0;
        end else if (flush) begin
            pc       <= target; // redirect wins over a stall.
            id_valid <= 1'b0;
        end else if (!bubble) begin
            pc       <= pc + 64'd4;
            id_valid <= 1'b1;
        end
    end

    // if/id payload.
    always_ff @(posedge clk) begin
        if (!bubble) begin
            id_pc   <= pc;
            id_inst <= inst;
        end
    end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`default_nettype none

module decode_stage import core_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  bubble,
    input  wire logic  flush,
    input  wire word_t id_pc,
    input  wire inst_t id_inst,
    input  wire logic  id_valid,
    input  wire word_t rs1_data,
    input  wire word_t rs2_data,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    output ctrl_t      ex_ctrl,
    output word_t      ex_pc,
    output word_t      ex_imm,
    output word_t      ex_rs1_data,
    output word_t      ex_rs2_data,
    output reg_addr_t  ex_rs1,
    output reg_addr_t  ex_rs2,
    output reg_addr_t  ex_rd,
    output logic       ex_valid
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t      imm;
    ctrl_t      ctrl;
    logic       kill;

    assign opcode = id_inst[6:0];
    assign funct3 = id_inst[14:12];
    assign funct7 = id_inst[31:25];
    assign rs1    = id_inst[19:15];
    assign rs2    = id_inst[24:20];

    assign imm_i = {{52{id_inst[31]}}, id_inst[31:20]};
    assign imm_s = {{52{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
    assign imm_b = {{51{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign imm_u = {{32{id_inst[31]}}, id_inst[31:12], 12'b0};
    assign imm_j = {{43{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            op_store:  imm = imm_s;
            op_branch: imm = imm_b;
            op_lui:    imm = imm_u;
            op_jal:    imm = imm_j;
            default:   imm = imm_i;
        endcase
    end

    always_comb begin
        ctrl = nop_ctrl; // anything unsupported stays a nop.
        case (opcode)
            op_imm: begin
                if (funct3 == 3'b000) begin
                    ctrl.use_imm   = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
            end
            op_reg: begin
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = alu_add;
                    10'b0100000_000: ctrl.alu_op = alu_sub;
                    10'b0000000_111: ctrl.alu_op = alu_and;
                    10'b0000000_110: ctrl.alu_op = alu_or;
                    10'b0000000_100: ctrl.alu_op = alu_xor;
                    10'b0000000_010: ctrl.alu_op = alu_slt;
                    default:         ctrl = nop_ctrl;
                endcase
            end
            op_lui: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_load: begin
                if (funct3 == 3'b011) begin // ld only.
                    ctrl.use_imm   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                end
            end
            op_store: begin
                if (funct3 == 3'b011) begin
                    ctrl.use_imm   = 1'b1;
                    ctrl.mem_write = 1'b1;
                end
            end
            op_branch: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.branch_ne = funct3[0];
                end
            end
            op_jal: begin
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_link   = 1'b1;
            end
            default: ctrl = nop_ctrl;
        endcase
    end

    assign kill = bubble || flush || !id_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_ctrl  <= nop_ctrl;
            ex_valid <= 1'b0;
        end else begin
            ex_ctrl  <= kill ? nop_ctrl : ctrl;
            ex_valid <= !kill;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc       <= id_pc;
        ex_imm      <= imm;
        ex_rs1_data <= rs1_data;
        ex_rs2_data <= rs2_data;
        ex_rs1      <= rs1;
        ex_rs2      <= rs2;
        ex_rd       <= id_inst[11:7];
    end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`default_nettype none

module register_file import core_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire reg_addr_t rs1,
    input  wire reg_addr_t rs2,
    output word_t          rs1_data,
    output word_t          rs2_data,
    wb_bus_if.sink         wb
);

    word_t regs [32];
    logic  we;

    assign we = wb.valid && (wb.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-first, so decode sees the value retiring this cycle.
    assign rs1_data = (rs1 == '0) ? '0 : (we && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (we && wb.rd == rs2) ? wb.data : regs[rs2];

    a_x0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (wb.valid && wb.rd == '0) |=> (regs[0] == '0));

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`default_nettype none

module execute_stage import core_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire ctrl_t     ex_ctrl,
    input  wire word_t     ex_pc,
    input  wire word_t     ex_imm,
    input  wire word_t     ex_rs1_data,
    input  wire word_t     ex_rs2_data,
    input  wire reg_addr_t ex_rs1,
    input  wire reg_addr_t ex_rs2,
    input  wire reg_addr_t ex_rd,
    input  wire logic      ex_valid,
    wb_bus_if.sink         me,
    wb_bus_if.sink         wb,
    output logic           flush,
    output word_t          target,
    output ctrl_t          mem_ctrl,
    output word_t          mem_alu,
    output word_t          mem_store_data,
    output word_t          mem_pc,
    output reg_addr_t      mem_rd,
    output logic           mem_valid
);

    logic  me_ok, wb_ok;
    word_t op_a, op_b, src_b, alu_res;
    logic  equal;

    // load data is not ready on the memory bus, the hazard unit covers that case.
    assign me_ok = me.valid && (me.rd != '0) && !me.is_load;
    assign wb_ok = wb.valid && (wb.rd != '0);

    assign op_a = (me_ok && me.rd == ex_rs1) ? me.data :
                  (wb_ok && wb.rd == ex_rs1) ? wb.data : ex_rs1_data;
    assign op_b = (me_ok && me.rd == ex_rs2) ? me.data :
                  (wb_ok && wb.rd == ex_rs2) ? wb.data : ex_rs2_data;

    assign src_b = ex_ctrl.use_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_ctrl.alu_op)
            alu_add:    alu_res = op_a + src_b;
            alu_sub:    alu_res = op_a - src_b;
            alu_and:    alu_res = op_a & src_b;
            alu_or:     alu_res = op_a | src_b;
            alu_xor:    alu_res = op_a ^ src_b;
            alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(src_b)};
            alu_pass_b: alu_res = src_b;
            default:    alu_res = '0;
        endcase
    end

    assign equal  = (op_a == op_b);
    assign flush  = ex_valid &&
                    (ex_ctrl.is_jal || (ex_ctrl.is_branch && (equal ^ ex_ctrl.branch_ne)));
    assign target = ex_pc + ex_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ctrl  <= nop_ctrl;
            mem_valid <= 1'b0;
        end else begin
            mem_ctrl  <= ex_ctrl;
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu        <= alu_res;
        mem_store_data <= op_b;
        mem_pc         <= ex_pc;
        mem_rd         <= ex_rd;
    end

    // squash of id/ex leaves execute empty right after a redirect.
    a_flush_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> ex_valid ##1 !flush);

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`default_nettype none

module hazard_unit import core_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire reg_addr_t rs1,
    input  wire reg_addr_t rs2,
    input  wire ctrl_t     ex_ctrl,
    input  wire reg_addr_t ex_rd,
    input  wire logic      ex_valid,
    input  wire logic      flush,
    output logic           bubble
);

    logic load_use;

    assign load_use = ex_valid && ex_ctrl.mem_read && (ex_rd != '0) &&
                      (ex_rd == rs1 || ex_rd == rs2);
    assign bubble   = load_use && !flush; // redirect drops the consumer anyway.

    // the nop behind a stall can never be a load.
    a_single_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        bubble |=> !bubble);

endmodule

`default_nettype wire

/* rtl/memory_stage.sv */
`default_nettype none

module memory_stage import core_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire ctrl_t     mem_ctrl,
    input  wire word_t     mem_alu,
    input  wire word_t     mem_store_data,
    input  wire word_t     mem_pc,
    input  wire reg_addr_t mem_rd,
    input  wire logic      mem_valid,
    wb_bus_if.source       me,
    wb_bus_if.source       wb
);

    word_t      dmem [dmem_depth];
    dmem_addr_t idx;
    word_t      result;
    logic       wb_valid, wb_is_load;
    reg_addr_t  wb_rd;
    word_t      wb_data;

    assign idx = mem_alu[8:3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_valid && mem_ctrl.mem_write) begin
            dmem[idx] <= mem_store_data;
        end
    end

    assign result = mem_ctrl.mem_read ? dmem[idx] :
                    mem_ctrl.wb_link  ? mem_pc + 64'd4 : mem_alu;

    assign me.valid   = mem_valid && mem_ctrl.reg_write;
    assign me.rd      = mem_rd;
    assign me.data    = result;
    assign me.is_load = mem_ctrl.mem_read;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= me.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd      <= mem_rd;
        wb_data    <= result;
        wb_is_load <= mem_ctrl.mem_read;
    end

    assign wb.valid   = wb_valid;
    assign wb.rd      = wb_rd;
    assign wb.data    = wb_data;
    assign wb.is_load = wb_is_load;

    a_dword_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_valid && (mem_ctrl.mem_read || mem_ctrl.mem_write)) |-> (mem_alu[2:0] == 3'b0));

endmodule

`default_nettype wire

/* rtl/core_top.sv */
`default_nettype none

module core_top import core_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    output word_t      pc,
    input  wire inst_t inst,
    output logic       commit_valid,
    output reg_addr_t  commit_rd,
    output word_t      commit_data
);

    logic      bubble, flush;
    word_t     target;
    word_t     id_pc;
    inst_t     id_inst;
    logic      id_valid;
    reg_addr_t rs1, rs2;
    word_t     rs1_data, rs2_data;
    ctrl_t     ex_ctrl;
    word_t     ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
    reg_addr_t ex_rs1, ex_rs2, ex_rd;
    logic      ex_valid;
    ctrl_t     mem_ctrl;
    word_t     mem_alu, mem_store_data, mem_pc;
    reg_addr_t mem_rd;
    logic      mem_valid;

    wb_bus_if me_bus ();
    wb_bus_if wb_bus ();

    fetch_stage u_fetch (
        .clk, .rst_n, .bubble, .flush, .target, .inst, .pc,
        .id_pc, .id_inst, .id_valid
    );

    decode_stage u_decode (
        .clk, .rst_n, .bubble, .flush, .id_pc, .id_inst, .id_valid,
        .rs1_data, .rs2_data, .rs1, .rs2,
        .ex_ctrl, .ex_pc, .ex_imm, .ex_rs1_data, .ex_rs2_data,
        .ex_rs1, .ex_rs2, .ex_rd, .ex_valid
    );

    register_file u_regs (
        .clk, .rst_n, .rs1, .rs2, .rs1_data, .rs2_data, .wb(wb_bus.sink)
    );

    hazard_unit u_hazard (
        .clk, .rst_n, .rs1, .rs2, .ex_ctrl, .ex_rd, .ex_valid, .flush, .bubble
    );

    execute_stage u_execute (
        .clk, .rst_n, .ex_ctrl, .ex_pc, .ex_imm, .ex_rs1_data, .ex_rs2_data,
        .ex_rs1, .ex_rs2, .ex_rd, .ex_valid,
        .me(me_bus.sink), .wb(wb_bus.sink),
        .flush, .target, .mem_ctrl, .mem_alu, .mem_store_data, .mem_pc,
        .mem_rd, .mem_valid
    );

    memory_stage u_memory (
        .clk, .rst_n, .mem_ctrl, .mem_alu, .mem_store_data, .mem_pc,
        .mem_rd, .mem_valid, .me(me_bus.source), .wb(wb_bus.source)
    );

    // retire port for the checker.
    assign commit_valid = wb_bus.valid;
    assign commit_rd    = wb_bus.rd;
    assign commit_data  = wb_bus.data;

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk; // period 40.
        end
    end

endmodule

`default_nettype wire

/* verification/core_tb.sv */
`default_nettype none

module core_tb import core_pkg::*; ();

    logic      clk;
    logic      rst_n;
    word_t     pc;
    inst_t     inst;
    logic      commit_valid;
    reg_addr_t commit_rd;
    word_t     commit_data;

    inst_t     rom [64];
    inst_t     program_q [$];
    string     exp_name [$];
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];
    word_t     xr [32]; // expected register contents.
    integer    seed;
    logic [31:0] r;
    logic [11:0] imm1, imm2;
    logic [19:0] uimm;
    int        cycle_count = 0;
    int        timeout_cycles = 1000;
    int        since_reset = 0;

    tb_clock u_clock (.clk);

    core_top core_top_inst (
        .clk, .rst_n, .pc, .inst, .commit_valid, .commit_rd, .commit_data
    );

    function automatic inst_t i_type(input logic [6:0] opcode, input reg_addr_t rd,
                                     input logic [2:0] funct3, input reg_addr_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic inst_t r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic inst_t s_type(input reg_addr_t rs1, input reg_addr_t rs2,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011}; // sd.
    endfunction

    function automatic inst_t b_type(input logic [2:0] funct3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic inst_t u_type(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111}; // lui.
    endfunction

    function automatic inst_t j_type(input reg_addr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t sign_extend_12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    // past the program everything reads as addi x0, x0, 0.
    function automatic inst_t fetch_word(input word_t addr);
        if (addr[63:8] != '0) begin
            return 32'h0000_0013;
        end
        return rom[addr[7:2]];
    endfunction

    task automatic put_inst(input inst_t w);
        program_q.push_back(w);
    endtask

    task automatic expect_commit(input string name, input reg_addr_t rd, input word_t value);
        exp_name.push_back(name);
        exp_rd.push_back(rd);
        exp_data.push_back(value);
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("error: %s expected 0x%h actual 0x%h",
                                        name, expected, actual));
        end
    endtask

    task automatic wait_for_commit();
        do begin
            @(negedge clk);
        end while (!(rst_n && commit_valid && commit_rd != '0));
    endtask

    // rom answers a little after the edge that moved pc.
    always @(posedge clk) begin
        #1;
        inst = fetch_word(pc);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            stop_with_failure($sformatf("timeout: no progress after %0d cycles", cycle_count));
        end
    end

    // first commit lands four cycles after reset release.
    always @(negedge clk) begin
        if (!rst_n) begin
            if (commit_valid) begin
                stop_with_failure("commit_valid went high during reset");
            end
            check_value("pc during reset", '0, pc);
        end else begin
            if (since_reset < 4 && commit_valid) begin
                stop_with_failure("commit_valid went high too early after reset");
            end
            if (since_reset == 4 && !commit_valid) begin
                stop_with_failure("first instruction did not commit four cycles after reset");
            end
            since_reset <= since_reset + 1;
        end
    end

    initial begin
        rst_n = 1'b0;
        inst  = 32'h0000_0013;
        seed  = 69;
        r = $random(seed);
        imm1 = r[11:0];
        r = $random(seed);
        imm2 = r[11:0];
        r = $random(seed);
        uimm = r[19:0];

        // dependent alu chain.
        xr[1] = sign_extend_12(imm1);
        put_inst(i_type(7'h13, 5'd1, 3'b000, 5'd0, imm1));
        expect_commit("addi x1", 5'd1, xr[1]);
        xr[2] = xr[1] + sign_extend_12(imm2);
        put_inst(i_type(7'h13, 5'd2, 3'b000, 5'd1, imm2));
        expect_commit("addi x2", 5'd2, xr[2]);
        xr[3] = xr[1] + xr[2];
        put_inst(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        expect_commit("add x3", 5'd3, xr[3]);
        xr[4] = xr[3] - xr[1];
        put_inst(r_type(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        expect_commit("sub x4", 5'd4, xr[4]);
        xr[5] = xr[4] & xr[3];
        put_inst(r_type(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
        expect_commit("and x5", 5'd5, xr[5]);
        xr[6] = xr[5] | xr[1];
        put_inst(r_type(7'h00, 3'b110, 5'd6, 5'd5, 5'd1));
        expect_commit("or x6", 5'd6, xr[6]);
        xr[7] = xr[6] ^ xr[2];
        put_inst(r_type(7'h00, 3'b100, 5'd7, 5'd6, 5'd2));
        expect_commit("xor x7", 5'd7, xr[7]);
        xr[8] = ($signed(xr[1]) < $signed(xr[2])) ? 64'd1 : 64'd0;
        put_inst(r_type(7'h00, 3'b010, 5'd8, 5'd1, 5'd2));
        expect_commit("slt x8", 5'd8, xr[8]);
        xr[9] = {{32{uimm[19]}}, uimm, 12'h000};
        put_inst(u_type(5'd9, uimm));
        expect_commit("lui x9", 5'd9, xr[9]);
        xr[9] = xr[9] + xr[7];
        put_inst(r_type(7'h00, 3'b000, 5'd9, 5'd9, 5'd7));
        expect_commit("add x9", 5'd9, xr[9]);

        // store, load back, then a load-use add.
        xr[10] = 64'd64;
        put_inst(i_type(7'h13, 5'd10, 3'b000, 5'd0, 12'd64));
        expect_commit("addi x10", 5'd10, xr[10]);
        put_inst(s_type(5'd10, 5'd9, 12'd8));
        xr[11] = xr[9];
        put_inst(i_type(7'h03, 5'd11, 3'b011, 5'd10, 12'd8));
        expect_commit("ld x11", 5'd11, xr[11]);
        xr[12] = xr[11] + xr[3];
        put_inst(r_type(7'h00, 3'b000, 5'd12, 5'd11, 5'd3));
        expect_commit("load-use add x12", 5'd12, xr[12]);

        // x0 ignores the write.
        put_inst(i_type(7'h13, 5'd0, 3'b000, 5'd0, 12'd5));
        xr[13] = xr[12];
        put_inst(r_type(7'h00, 3'b000, 5'd13, 5'd0, 5'd12));
        expect_commit("add x13 from x0", 5'd13, xr[13]);

        // taken beq and jal, each skipping two.
        put_inst(b_type(3'b000, 5'd13, 5'd12, 13'd12));
        put_inst(i_type(7'h13, 5'd14, 3'b000, 5'd0, 12'd111));
        put_inst(i_type(7'h13, 5'd15, 3'b000, 5'd0, 12'd222));
        xr[16] = 64'd80; // jal sits at 76.
        put_inst(j_type(5'd16, 21'd12));
        expect_commit("jal x16", 5'd16, xr[16]);
        put_inst(i_type(7'h13, 5'd14, 3'b000, 5'd0, 12'd333));
        put_inst(i_type(7'h13, 5'd15, 3'b000, 5'd0, 12'd444));

        // bne not taken.
        put_inst(b_type(3'b001, 5'd1, 5'd1, 13'd8));
        xr[17] = xr[16] + 64'd1;
        put_inst(i_type(7'h13, 5'd17, 3'b000, 5'd16, 12'd1));
        expect_commit("addi x17", 5'd17, xr[17]);
        xr[18] = xr[17] + 64'd2;
        put_inst(i_type(7'h13, 5'd18, 3'b000, 5'd17, 12'd2));
        expect_commit("addi x18", 5'd18, xr[18]);
        xr[19] = xr[17] + xr[18];
        put_inst(r_type(7'h00, 3'b000, 5'd19, 5'd17, 5'd18));
        expect_commit("add x19", 5'd19, xr[19]);

        for (int i = 0; i < 64; i++) begin
            rom[i] = (i < program_q.size()) ? program_q[i] : 32'h0000_0013;
        end
        inst = fetch_word('0);
        timeout_cycles = exp_rd.size() * 8 + 40;

        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int i = 0; i < exp_rd.size(); i++) begin
            wait_for_commit();
            check_value({exp_name[i], " rd"}, word_t'(exp_rd[i]), word_t'(commit_rd));
            check_value(exp_name[i], exp_data[i], commit_data);
        end

        // skipped instructions must not show up late.
        repeat (12) begin
            @(negedge clk);
            if (commit_valid && commit_rd != '0) begin
                stop_with_failure($sformatf("unexpected commit to x%0d after the last one",
                                            commit_rd));
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
rtl/core_pkg.sv
rtl/wb_bus_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/hazard_unit.sv
rtl/memory_stage.sv
rtl/core_top.sv
verification/tb_clock.sv
verification/core_tb.sv

/* Bender.yml */
package:
  name: rv64i_pipeline

sources:
  - rtl/core_pkg.sv
  - rtl/wb_bus_if.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/register_file.sv
  - rtl/execute_stage.sv
  - rtl/hazard_unit.sv
  - rtl/memory_stage.sv
  - rtl/core_top.sv
  - target: simulation
    files:
      - verification/tb_clock.sv
      - verification/core_tb.sv
